//--- rtl/dense_net_macros.svh
`ifndef DENSE_NET_MACROS_SVH
`define DENSE_NET_MACROS_SVH

`define DN_DATA_W       16
`define DN_IDX_W        4
`define DN_MAX_NEURONS  12

// Layer sizes, input count of layer k is the output count of layer k-1
`define DN_L1_IN        2
`define DN_L1_OUT       8
`define DN_L2_OUT       12
`define DN_L3_OUT       6
`define DN_L4_OUT       4
`define DN_L5_OUT       1

// Weight masks, bit i set adds input i plain, clear adds it inverted
`define DN_W_L1_N0      2'b00
`define DN_W_L1_N1      2'b00
`define DN_W_L1_N2      2'b01
`define DN_W_L1_N3      2'b10
`define DN_W_L1_N4      2'b10
`define DN_W_L1_N5      2'b00
`define DN_W_L1_N6      2'b10
`define DN_W_L1_N7      2'b10

`define DN_W_L2_N0      8'b0110_0101
`define DN_W_L2_N1      8'b1101_0001
`define DN_W_L2_N2      8'b0010_0101
`define DN_W_L2_N3      8'b1111_0001
`define DN_W_L2_N4      8'b0010_1111
`define DN_W_L2_N5      8'b1000_1110
`define DN_W_L2_N6      8'b1001_0010
`define DN_W_L2_N7      8'b1111_1000
`define DN_W_L2_N8      8'b1100_1111
`define DN_W_L2_N9      8'b0010_1111
`define DN_W_L2_N10     8'b1100_1001
`define DN_W_L2_N11     8'b1110_0111

`define DN_W_L3_N0      12'b1111_0010_0100
`define DN_W_L3_N1      12'b1111_0010_0110
`define DN_W_L3_N2      12'b0101_1001_0010
`define DN_W_L3_N3      12'b0001_1101_1101
`define DN_W_L3_N4      12'b1111_0111_1000
`define DN_W_L3_N5      12'b1100_1100_1100

`define DN_W_L4_N0      6'b000000
`define DN_W_L4_N1      6'b000000
`define DN_W_L4_N2      6'b010011
`define DN_W_L4_N3      6'b010011

`define DN_W_L5_N0      4'b1111

// Sigmoid in Q10, breakpoints are inclusive upper bounds
`define DN_SIG_BP1      16'd1024
`define DN_SIG_BP2      16'd2432
`define DN_SIG_BP3      16'd5120
`define DN_SIG_OFS0     16'd512
`define DN_SIG_OFS1     16'd640
`define DN_SIG_OFS2     16'd864
`define DN_SIG_OFS3     16'd1024
`define DN_SIG_HALF     16'd512

`endif

//--- rtl/dense_net_pkg.sv
`default_nettype none

`include "dense_net_macros.svh"

package dense_net_pkg;

    typedef logic [`DN_DATA_W-1:0] data_t;

    typedef enum logic [2:0] {
        L1,
        L2,
        L3,
        L4,
        L5
    } layer_e;

    typedef enum logic [2:0] {
        IDLE,
        CLEAR,
        ACCUM,
        STORE,
        SIGMOID,
        FINISH
    } seq_state_e;

    typedef struct packed {
        data_t x1;
        data_t x2;
    } feature_t;

    // One step of the datapath, bank is the bank read in layers 2 to 5
    typedef struct packed {
        layer_e                layer;
        logic [`DN_IDX_W-1:0] neuron_idx;
        logic [`DN_IDX_W-1:0] input_idx;
        logic                  clear;
        logic                  accum;
        logic                  store;
        logic                  sigmoid;
        logic                  bank;
    } step_ctrl_t;

endpackage

`default_nettype wire

//--- rtl/layer_sequencer.sv
`timescale 1ns/1ns
`default_nettype none

`include "dense_net_macros.svh"

module layer_sequencer (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire                    start_i,
    input  wire                    last_input_i,
    input  wire                    last_neuron_i,
    input  wire [`DN_IDX_W-1:0]    neuron_idx_i,
    input  wire [`DN_IDX_W-1:0]    input_idx_i,
    output dense_net_pkg::step_ctrl_t ctrl_o,
    output logic                   advance_o,
    output logic                   restart_o,
    output logic                   busy_o,
    output logic                   done_o
);

    dense_net_pkg::seq_state_e state_q;
    dense_net_pkg::seq_state_e state_d;
    dense_net_pkg::layer_e     layer_q;
    dense_net_pkg::layer_e     layer_d;
    logic                      bank_q;
    logic                      bank_d;

    always_comb
    begin
        state_d = state_q;
        layer_d = layer_q;
        bank_d  = bank_q;
        case (state_q)
            dense_net_pkg::IDLE:
            begin
                if (start_i)
                begin
                    state_d = dense_net_pkg::CLEAR;
                    layer_d = dense_net_pkg::L1;
                    bank_d  = 1'b0;
                end
            end
            dense_net_pkg::CLEAR:
                state_d = dense_net_pkg::ACCUM;
            dense_net_pkg::ACCUM:
            begin
                if (last_input_i)
                    state_d = dense_net_pkg::STORE;
            end
            dense_net_pkg::STORE:
            begin
                if (!last_neuron_i)
                    state_d = dense_net_pkg::CLEAR;
                else if (layer_q == dense_net_pkg::L5)
                    state_d = dense_net_pkg::SIGMOID;
                else
                begin
                    // Next layer reads what this one wrote
                    state_d = dense_net_pkg::CLEAR;
                    layer_d = dense_net_pkg::layer_e'(layer_q + 3'd1);
                    bank_d  = ~bank_q;
                end
            end
            dense_net_pkg::SIGMOID:
                state_d = dense_net_pkg::FINISH;
            default:
                state_d = dense_net_pkg::IDLE;
        endcase
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            state_q <= dense_net_pkg::IDLE;
            layer_q <= dense_net_pkg::L1;
            bank_q  <= 1'b0;
        end
        else
        begin
            state_q <= state_d;
            layer_q <= layer_d;
            bank_q  <= bank_d;
        end
    end

    assign ctrl_o.layer      = layer_q;
    assign ctrl_o.neuron_idx = neuron_idx_i;
    assign ctrl_o.input_idx  = input_idx_i;
    assign ctrl_o.clear      = (state_q == dense_net_pkg::CLEAR);
    assign ctrl_o.accum      = (state_q == dense_net_pkg::ACCUM);
    assign ctrl_o.store      = (state_q == dense_net_pkg::STORE);
    assign ctrl_o.sigmoid    = (state_q == dense_net_pkg::SIGMOID);
    assign ctrl_o.bank       = bank_q;

    // Input index parks on the last input until STORE wraps it
    assign advance_o = (ctrl_o.accum && !last_input_i) || ctrl_o.store;
    assign restart_o = ((state_q == dense_net_pkg::IDLE) && start_i)
                     || (ctrl_o.store && last_neuron_i);

    assign busy_o = (state_q != dense_net_pkg::IDLE);
    assign done_o = (state_q == dense_net_pkg::FINISH);

endmodule

`default_nettype wire

//--- rtl/index_counter.sv
`timescale 1ns/1ns
`default_nettype none

`include "dense_net_macros.svh"

module index_counter (
    input  wire                    clk,
    input  wire                    rst_n_i,
    input  wire dense_net_pkg::layer_e layer_i,
    input  wire                    advance_i,
    input  wire                    restart_i,
    output logic [`DN_IDX_W-1:0]   neuron_idx_o,
    output logic [`DN_IDX_W-1:0]   input_idx_o,
    output logic                   last_input_o,
    output logic                   last_neuron_o
);

    logic [`DN_IDX_W-1:0] in_last;
    logic [`DN_IDX_W-1:0] out_last;

    // Highest index of each layer
    always_comb
    begin
        case (layer_i)
            dense_net_pkg::L1:
            begin
                in_last  = `DN_IDX_W'(`DN_L1_IN - 1);
                out_last = `DN_IDX_W'(`DN_L1_OUT - 1);
            end
            dense_net_pkg::L2:
            begin
                in_last  = `DN_IDX_W'(`DN_L1_OUT - 1);
                out_last = `DN_IDX_W'(`DN_L2_OUT - 1);
            end
            dense_net_pkg::L3:
            begin
                in_last  = `DN_IDX_W'(`DN_L2_OUT - 1);
                out_last = `DN_IDX_W'(`DN_L3_OUT - 1);
            end
            dense_net_pkg::L4:
            begin
                in_last  = `DN_IDX_W'(`DN_L3_OUT - 1);
                out_last = `DN_IDX_W'(`DN_L4_OUT - 1);
            end
            default:
            begin
                in_last  = `DN_IDX_W'(`DN_L4_OUT - 1);
                out_last = `DN_IDX_W'(`DN_L5_OUT - 1);
            end
        endcase
    end

    assign last_input_o  = (input_idx_o == in_last);
    assign last_neuron_o = (neuron_idx_o == out_last);

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            neuron_idx_o <= '0;
            input_idx_o  <= '0;
        end
        else if (restart_i)
        begin
            neuron_idx_o <= '0;
            input_idx_o  <= '0;
        end
        else if (advance_i)
        begin
            if (last_input_o)
            begin
                input_idx_o  <= '0;
                neuron_idx_o <= last_neuron_o ? '0 : neuron_idx_o + 1'b1;
            end
            else
                input_idx_o <= input_idx_o + 1'b1;
        end
    end

endmodule

`default_nettype wire

//--- rtl/neuron_accumulator.sv
`timescale 1ns/1ns
`default_nettype none

`include "dense_net_macros.svh"

module neuron_accumulator (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire dense_net_pkg::step_ctrl_t ctrl_i,
    input  wire dense_net_pkg::data_t  operand_i,
    output dense_net_pkg::data_t       sum_o,
    output dense_net_pkg::data_t       act_o
);

    // Masks per layer, neuron n sits at bits [n*inputs +: inputs]
    localparam logic [`DN_L1_OUT*`DN_L1_IN-1:0] w_tbl_l1 = {
        `DN_W_L1_N7, `DN_W_L1_N6, `DN_W_L1_N5, `DN_W_L1_N4,
        `DN_W_L1_N3, `DN_W_L1_N2, `DN_W_L1_N1, `DN_W_L1_N0};
    localparam logic [`DN_L2_OUT*`DN_L1_OUT-1:0] w_tbl_l2 = {
        `DN_W_L2_N11, `DN_W_L2_N10, `DN_W_L2_N9, `DN_W_L2_N8,
        `DN_W_L2_N7, `DN_W_L2_N6, `DN_W_L2_N5, `DN_W_L2_N4,
        `DN_W_L2_N3, `DN_W_L2_N2, `DN_W_L2_N1, `DN_W_L2_N0};
    localparam logic [`DN_L3_OUT*`DN_L2_OUT-1:0] w_tbl_l3 = {
        `DN_W_L3_N5, `DN_W_L3_N4, `DN_W_L3_N3,
        `DN_W_L3_N2, `DN_W_L3_N1, `DN_W_L3_N0};
    localparam logic [`DN_L4_OUT*`DN_L3_OUT-1:0] w_tbl_l4 = {
        `DN_W_L4_N3, `DN_W_L4_N2, `DN_W_L4_N1, `DN_W_L4_N0};
    localparam logic [`DN_L5_OUT*`DN_L4_OUT-1:0] w_tbl_l5 = `DN_W_L5_N0;

    logic                 w_plain;
    dense_net_pkg::data_t term;
    dense_net_pkg::data_t acc_q;

    always_comb
    begin
        case (ctrl_i.layer)
            dense_net_pkg::L1:
                w_plain = w_tbl_l1[ctrl_i.neuron_idx * `DN_L1_IN + ctrl_i.input_idx];
            dense_net_pkg::L2:
                w_plain = w_tbl_l2[ctrl_i.neuron_idx * `DN_L1_OUT + ctrl_i.input_idx];
            dense_net_pkg::L3:
                w_plain = w_tbl_l3[ctrl_i.neuron_idx * `DN_L2_OUT + ctrl_i.input_idx];
            dense_net_pkg::L4:
                w_plain = w_tbl_l4[ctrl_i.neuron_idx * `DN_L3_OUT + ctrl_i.input_idx];
            default:
                w_plain = w_tbl_l5[ctrl_i.neuron_idx * `DN_L4_OUT + ctrl_i.input_idx];
        endcase
    end

    // A -1 weight adds the one's complement
    assign term = w_plain ? operand_i : ~operand_i;

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
            acc_q <= '0;
        else if (ctrl_i.clear)
            acc_q <= '0;
        else if (ctrl_i.accum)
            acc_q <= acc_q + term;
    end

    assign sum_o = acc_q;
    // Hidden layers clamp negative sums, the output neuron passes raw
    assign act_o = (ctrl_i.layer == dense_net_pkg::L5 || !acc_q[`DN_DATA_W-1]) ? acc_q : '0;

endmodule

`default_nettype wire

//--- rtl/activation_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "dense_net_macros.svh"

module activation_buffer (
    input  wire                        clk,
    input  wire                        rst_n_i,
    input  wire dense_net_pkg::step_ctrl_t ctrl_i,
    input  wire dense_net_pkg::feature_t features_i,
    input  wire dense_net_pkg::data_t  act_i,
    output dense_net_pkg::data_t       operand_o
);

    dense_net_pkg::data_t bank_mem [2][`DN_MAX_NEURONS];

    // Writes go to the bank that is not being read
    always_ff @(posedge clk)
    begin
        if (rst_n_i && ctrl_i.store)
            bank_mem[!ctrl_i.bank][ctrl_i.neuron_idx] <= act_i;
    end

    always_comb
    begin
        if (ctrl_i.layer == dense_net_pkg::L1)
            operand_o = ctrl_i.input_idx[0] ? features_i.x2 : features_i.x1;
        else
            operand_o = bank_mem[ctrl_i.bank][ctrl_i.input_idx];
    end

endmodule

`default_nettype wire

//--- rtl/sigmoid_decision.sv
`timescale 1ns/1ns
`default_nettype none

`include "dense_net_macros.svh"

module sigmoid_decision (
    input  wire                       clk,
    input  wire                       rst_n_i,
    input  wire                       load_i,
    input  wire dense_net_pkg::data_t sum_i,
    output dense_net_pkg::data_t      score_o,
    output logic                      class_o
);

    dense_net_pkg::data_t score_d;

    // Four linear pieces, sum taken as unsigned
    always_comb
    begin
        if (sum_i <= `DN_SIG_BP1)
            score_d = (sum_i >> 2) + `DN_SIG_OFS0;
        else if (sum_i <= `DN_SIG_BP2)
            score_d = (sum_i >> 3) + `DN_SIG_OFS1;
        else if (sum_i <= `DN_SIG_BP3)
            score_d = (sum_i >> 5) + `DN_SIG_OFS2;
        else
            score_d = `DN_SIG_OFS3;
    end

    always_ff @(posedge clk)
    begin
        if (!rst_n_i)
        begin
            score_o <= '0;
            class_o <= 1'b0;
        end
        else if (load_i)
        begin
            score_o <= score_d;
            class_o <= (score_d > `DN_SIG_HALF);
        end
    end

endmodule

`default_nettype wire

//--- rtl/dense_net_top.sv
`timescale 1ns/1ns
`default_nettype none

`include "dense_net_macros.svh"

module dense_net_top (
    input  wire                          clk,
    input  wire                          rst_n_i,
    input  wire                          start_i,
    input  wire dense_net_pkg::feature_t feature_i,
    output logic                         busy_o,
    output logic                         done_o,
    output logic                         class_o,
    output dense_net_pkg::data_t         score_o
);

    dense_net_pkg::feature_t   feature_q;
    dense_net_pkg::step_ctrl_t ctrl;
    dense_net_pkg::data_t      operand;
    dense_net_pkg::data_t      act;
    dense_net_pkg::data_t      sum;
    logic                      advance;
    logic                      restart;
    logic                      last_input;
    logic                      last_neuron;
    logic [`DN_IDX_W-1:0]      neuron_idx;
    logic [`DN_IDX_W-1:0]      input_idx;

    // Samples held for the whole run
    always_ff @(posedge clk)
    begin
        if (start_i && !busy_o)
            feature_q <= feature_i;
    end

    layer_sequencer layer_sequencer_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .start_i       (start_i),
        .last_input_i  (last_input),
        .last_neuron_i (last_neuron),
        .neuron_idx_i  (neuron_idx),
        .input_idx_i   (input_idx),
        .ctrl_o        (ctrl),
        .advance_o     (advance),
        .restart_o     (restart),
        .busy_o        (busy_o),
        .done_o        (done_o)
    );

    index_counter index_counter_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .layer_i       (ctrl.layer),
        .advance_i     (advance),
        .restart_i     (restart),
        .neuron_idx_o  (neuron_idx),
        .input_idx_o   (input_idx),
        .last_input_o  (last_input),
        .last_neuron_o (last_neuron)
    );

    neuron_accumulator neuron_accumulator_i (
        .clk       (clk),
        .rst_n_i   (rst_n_i),
        .ctrl_i    (ctrl),
        .operand_i (operand),
        .sum_o     (sum),
        .act_o     (act)
    );

    activation_buffer activation_buffer_i (
        .clk        (clk),
        .rst_n_i    (rst_n_i),
        .ctrl_i     (ctrl),
        .features_i (feature_q),
        .act_i      (act),
        .operand_o  (operand)
    );

    sigmoid_decision sigmoid_decision_i (
        .clk     (clk),
        .rst_n_i (rst_n_i),
        .load_i  (ctrl.sigmoid),
        .sum_i   (sum),
        .score_o (score_o),
        .class_o (class_o)
    );

endmodule

`default_nettype wire

//--- tests/tb_clock_gen.sv
`timescale 1ns/1ns
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic rst_n_o
);

    initial
    begin
        clk     = 1'b0;
        rst_n_o = 1'b0;
        repeat (2) @(posedge clk);
        rst_n_o <= 1'b1;
    end

    // 8 ns period
    always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- tests/dense_net_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "dense_net_macros.svh"

module dense_net_tb;

    localparam int NUM_RUNS        = 22;
    localparam int WATCHDOG_CYCLES = NUM_RUNS * 300 + 100;
    // Each neuron costs CLEAR, one cycle per input and STORE, then SIGMOID and FINISH
    localparam int LATENCY = `DN_L1_OUT * (`DN_L1_IN + 2) + `DN_L2_OUT * (`DN_L1_OUT + 2)
                           + `DN_L3_OUT * (`DN_L2_OUT + 2) + `DN_L4_OUT * (`DN_L3_OUT + 2)
                           + `DN_L5_OUT * (`DN_L4_OUT + 2) + 2;

    logic                    clk;
    logic                    rst_n;
    logic                    start_i;
    dense_net_pkg::feature_t feature_i;
    logic                    busy_o;
    logic                    done_o;
    logic                    class_o;
    dense_net_pkg::data_t    score_o;

    logic [15:0] lfsr_q = 16'd73;
    int          done_count = 0;
    int          test_errors = 0;
    int          total_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;

    logic [`DN_L1_IN-1:0]  l1_masks [`DN_L1_OUT] = '{`DN_W_L1_N0, `DN_W_L1_N1, `DN_W_L1_N2,
        `DN_W_L1_N3, `DN_W_L1_N4, `DN_W_L1_N5, `DN_W_L1_N6, `DN_W_L1_N7};
    logic [`DN_L1_OUT-1:0] l2_masks [`DN_L2_OUT] = '{`DN_W_L2_N0, `DN_W_L2_N1, `DN_W_L2_N2,
        `DN_W_L2_N3, `DN_W_L2_N4, `DN_W_L2_N5, `DN_W_L2_N6, `DN_W_L2_N7, `DN_W_L2_N8,
        `DN_W_L2_N9, `DN_W_L2_N10, `DN_W_L2_N11};
    logic [`DN_L2_OUT-1:0] l3_masks [`DN_L3_OUT] = '{`DN_W_L3_N0, `DN_W_L3_N1, `DN_W_L3_N2,
        `DN_W_L3_N3, `DN_W_L3_N4, `DN_W_L3_N5};
    logic [`DN_L3_OUT-1:0] l4_masks [`DN_L4_OUT] = '{`DN_W_L4_N0, `DN_W_L4_N1, `DN_W_L4_N2,
        `DN_W_L4_N3};
    logic [`DN_L4_OUT-1:0] l5_masks [`DN_L5_OUT] = '{`DN_W_L5_N0};

    tb_clock_gen tb_clock_gen_i (
        .clk     (clk),
        .rst_n_o (rst_n)
    );

    dense_net_top dense_net_top_i (
        .clk       (clk),
        .rst_n_i   (rst_n),
        .start_i   (start_i),
        .feature_i (feature_i),
        .busy_o    (busy_o),
        .done_o    (done_o),
        .class_o   (class_o),
        .score_o   (score_o)
    );

    // Galois LFSR stepped once per bit
    function automatic logic [15:0] random_word();
        logic [15:0] word;
        word = '0;
        for (int b = 0; b < 16; b++)
        begin
            word  = {word[14:0], lfsr_q[0]};
            lfsr_q = lfsr_q[0] ? ((lfsr_q >> 1) ^ 16'hB400) : (lfsr_q >> 1);
        end
        return word;
    endfunction

    function automatic logic mask_bit(int layer, int n, int i);
        case (layer)
            1: return l1_masks[n][i];
            2: return l2_masks[n][i];
            3: return l3_masks[n][i];
            4: return l4_masks[n][i];
            default: return l5_masks[n][i];
        endcase
    endfunction

    // Raw output sum of the network
    function automatic logic [15:0] model_sum(logic [15:0] x1, logic [15:0] x2);
        int          sizes [6] = '{`DN_L1_IN, `DN_L1_OUT, `DN_L2_OUT, `DN_L3_OUT,
                                   `DN_L4_OUT, `DN_L5_OUT};
        logic [15:0] cur [12];
        logic [15:0] nxt [12];
        logic [15:0] acc;
        cur[0] = x1;
        cur[1] = x2;
        for (int layer = 1; layer <= 5; layer++)
        begin
            for (int n = 0; n < sizes[layer]; n++)
            begin
                acc = '0;
                for (int i = 0; i < sizes[layer-1]; i++)
                    acc = acc + (mask_bit(layer, n, i) ? cur[i] : ~cur[i]);
                nxt[n] = (layer < 5 && acc[15]) ? 16'd0 : acc;
            end
            cur = nxt;
        end
        return cur[0];
    endfunction

    function automatic logic [15:0] model_score(logic [15:0] s);
        int v;
        v = s;
        if (v <= 1024)
            return 16'(v / 4 + 512);
        else if (v <= 2432)
            return 16'(v / 8 + 640);
        else if (v <= 5120)
            return 16'(v / 32 + 864);
        return 16'd1024;
    endfunction

    task automatic check_value(input string name, input logic [15:0] got,
                               input logic [15:0] exp);
        assert (got == exp)
        else
        begin
            $display("FAIL %s got %h expected %h", name, got, exp);
            test_errors++;
        end
    endtask

    task automatic close_test(input string name);
        if (test_errors == 0)
        begin
            tests_passed++;
            $display("%s: ok", name);
        end
        else
        begin
            tests_failed++;
            $display("%s: %0d errors", name, test_errors);
        end
        total_errors += test_errors;
        test_errors = 0;
    endtask

    // One evaluation with optional start pulses and new samples while busy
    task automatic run_eval(input logic [15:0] x1, input logic [15:0] x2, input bit disturb);
        logic [15:0] exp_score;
        int          cycles;
        int          done_before;
        exp_score   = model_score(model_sum(x1, x2));
        done_before = done_count;
        @(posedge clk);
        start_i   <= 1'b1;
        feature_i <= {x1, x2};
        @(posedge clk);
        start_i <= 1'b0;
        cycles = 1;
        @(negedge clk);
        while (!done_o)
        begin
            check_value("busy_o", {15'd0, busy_o}, 16'd1);
            @(posedge clk);
            cycles++;
            if (disturb)
            begin
                start_i   <= (cycles % 64 == 10);
                feature_i <= {random_word(), random_word()};
            end
            @(negedge clk);
        end
        check_value("latency", 16'(cycles), 16'(LATENCY));
        check_value("score_o", score_o, exp_score);
        check_value("class_o", {15'd0, class_o}, {15'd0, exp_score > 16'd512});
        assert (score_o >= 16'd512 && score_o <= 16'd1024)
        else
        begin
            $display("score_o left the range 512 to 1024");
            test_errors++;
        end
        assert (class_o == (score_o > 16'd512))
        else
        begin
            $display("class_o does not follow the score threshold");
            test_errors++;
        end
        repeat (2) @(negedge clk);
        assert (!busy_o && !done_o)
        else
        begin
            $display("DUT did not return to idle after done");
            test_errors++;
        end
        check_value("done pulses", 16'(done_count - done_before), 16'd1);
    endtask

    always @(posedge clk)
    begin
        if (rst_n && done_o)
            done_count++;
    end

    initial
    begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("Watchdog expired before all runs finished");
        $display("Test failures found");
        $finish;
    end

    initial
    begin
        logic [15:0] x1;
        logic [15:0] x2;
        start_i   = 1'b0;
        feature_i = '0;
        wait (rst_n == 1'b1);
        @(negedge clk);
        check_value("busy_o", {15'd0, busy_o}, 16'd0);
        check_value("done_o", {15'd0, done_o}, 16'd0);
        check_value("class_o", {15'd0, class_o}, 16'd0);
        check_value("score_o", score_o, 16'd0);
        close_test("reset values");

        run_eval(16'd0, 16'd0, 1'b0);
        close_test("zero samples");

        for (int r = 0; r < 20; r++)
        begin
            x1 = random_word();
            x2 = random_word();
            run_eval(x1, x2, 1'b0);
            close_test($sformatf("random pair %0d (%h, %h)", r, x1, x2));
        end

        x1 = random_word();
        x2 = random_word();
        run_eval(x1, x2, 1'b1);
        close_test("start and samples changed while busy");

        $display("tests: %0d passed: %0d failed: %0d", tests_passed + tests_failed,
                 tests_passed, tests_failed);
        if (total_errors == 0)
            $display("All tests passed!");
        else
            $display("Test failures found");
        $finish;
    end

endmodule

`default_nettype wire

//--- dense_net_top.f
+incdir+rtl
rtl/dense_net_pkg.sv
rtl/layer_sequencer.sv
rtl/index_counter.sv
rtl/neuron_accumulator.sv
rtl/activation_buffer.sv
rtl/sigmoid_decision.sv
rtl/dense_net_top.sv
tests/tb_clock_gen.sv
tests/dense_net_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --timescale 1ns/1ns \
    -f dense_net_top.f --top-module dense_net_tb -o dense_net_sim \
    && ./obj_dir/dense_net_sim > sim.log 2>&1 \
    || { cat sim.log 2>/dev/null; echo "build or simulation error"; exit 1; }
cat sim.log
grep -q "Test failures found" sim.log && exit 1 || exit 0
